/* include/adcCtrl_cfg.svh */
`ifndef ADC_CTRL_CFG_SVH
`define ADC_CTRL_CFG_SVH

//////////////////////////////////////////////////////////////////////
// serial link geometry
//////////////////////////////////////////////////////////////////////

`define ADC_SCLK_DIV      16    // system clocks per sclk period
`define ADC_WORD_BITS     32    // bits per register word, sent lsb first
`define ADC_ROM_DEPTH     9     // entries in the register table

//////////////////////////////////////////////////////////////////////
// write sequences: first table entry and number of words
//////////////////////////////////////////////////////////////////////

`define ADC_INIT_ADDR     0     // full configuration, regs 0..7
`define ADC_INIT_WORDS    8
`define ADC_DESEN_ADDR    8     // reg 5 with dual-edge sampling on
`define ADC_DESEN_WORDS   1
`define ADC_DESDIS_ADDR   5     // standard reg 5 entry, des off
`define ADC_DESDIS_WORDS  1

//////////////////////////////////////////////////////////////////////
// register table contents
//////////////////////////////////////////////////////////////////////

// layout: [31:28] table index, [27:20] fixed header,
// [19:16] adc register address, [15:0] register data
`define ADC_REG0  32'h0010_B2FF   // config: output mode, test pattern off
`define ADC_REG1  32'h1011_07FF   // reserved, factory value
`define ADC_REG2  32'h2012_007F   // i-channel offset
`define ADC_REG3  32'h3013_807F   // i-channel full scale
`define ADC_REG4  32'h4014_007F   // q-channel offset
`define ADC_REG5  32'h5015_807F   // q-channel full scale, des off
`define ADC_REG6  32'h601D_DB7E   // extended config
`define ADC_REG7  32'h701F_001F   // clock phase adjust
`define ADC_REG8  32'h8015_C07F   // reg 5 again with des bit set

`endif

/* source/adcCtrlPkg.sv */
`include "adcCtrl_cfg.svh"

package adcCtrlPkg;

	//////////////////////////////////////////////////////////////////////
	// vector types with a meaning
	//////////////////////////////////////////////////////////////////////

	// table address, wide enough for every entry
	typedef logic [$clog2(`ADC_ROM_DEPTH)-1:0] regAddr_t;

	// one register word exactly as it goes out on sdata
	typedef logic [`ADC_WORD_BITS-1:0] regWord_t;

	typedef logic [$clog2(`ADC_WORD_BITS)-1:0] bitIdx_t;   // bit being sent
	typedef logic [$clog2(`ADC_SCLK_DIV)-1:0]  divCnt_t;   // sclk divider

	//////////////////////////////////////////////////////////////////////
	// sequencer fsm
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		seqIdle   = 2'd0,   // waiting for a command pulse
		seqLoad   = 2'd1,   // hand current table word to serializer
		seqShift  = 2'd2,   // serializer busy with the word
		seqFinish = 2'd3    // done strobe
	} seqState_t;

endpackage

/* source/adcSerialIf.sv */
`timescale 1ns/1ps

// link between command sequencer and serializer
interface adcSerialIf;
	import adcCtrlPkg::*;

	logic     frame;      // level, high across the whole write sequence
	logic     start;      // one-cycle pulse, load word and begin shifting
	regWord_t word;       // valid together with start
	logic     wordDone;   // one-cycle pulse, last bit period is ending

	// sequencer side
	modport seq (
		output frame,
		output start,
		output word,
		input  wordDone
	);

	// serializer side
	modport ser (
		input  frame,
		input  start,
		input  word,
		output wordDone
	);

endinterface

/* source/adcRegRom.sv */
`timescale 1ns/1ps
`include "adcCtrl_cfg.svh"

// register table, purely combinational
module adcRegRom (
	input  adcCtrlPkg::regAddr_t addr,
	output adcCtrlPkg::regWord_t data
);
	import adcCtrlPkg::*;

	//////////////////////////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		data = '0;                                    // unused addresses read zero
		if (addr < regAddr_t'(`ADC_ROM_DEPTH)) begin
			case (addr)
				regAddr_t'(0): data = `ADC_REG0;      // start of init run
				regAddr_t'(1): data = `ADC_REG1;
				regAddr_t'(2): data = `ADC_REG2;
				regAddr_t'(3): data = `ADC_REG3;
				regAddr_t'(4): data = `ADC_REG4;
				regAddr_t'(5): data = `ADC_REG5;      // also the des disable word
				regAddr_t'(6): data = `ADC_REG6;
				regAddr_t'(7): data = `ADC_REG7;      // end of init run
				regAddr_t'(8): data = `ADC_REG8;      // des enable word
				default:       data = '0;
			endcase
		end
	end

endmodule

/* source/adcSerializer.sv */
`timescale 1ns/1ps
`include "adcCtrl_cfg.svh"

// shifts one table word out lsb first under a divided serial clock
module adcSerializer (
	input  logic    clk,
	input  logic    rstN,
	adcSerialIf.ser link,
	output logic    sclk,
	output logic    sdata,
	output logic    selectN
);
	import adcCtrlPkg::*;

	localparam divCnt_t DIV_LAST = divCnt_t'(`ADC_SCLK_DIV - 1);  // end of a bit period
	localparam divCnt_t DIV_DONE = divCnt_t'(`ADC_SCLK_DIV - 2);  // one clock before that
	localparam bitIdx_t BIT_LAST = bitIdx_t'(`ADC_WORD_BITS - 1);

	regWord_t wordQ;      // word being shifted
	divCnt_t  divCnt;     // position inside the bit period
	bitIdx_t  bitIdx;     // bit currently on sdata
	bitIdx_t  nextIdx;
	logic     busy;       // divider running
	logic     divWrap;    // last clock of a bit period
	logic     lastBit;

	assign divWrap = busy && (divCnt == DIV_LAST);
	assign lastBit = (bitIdx == BIT_LAST);
	assign nextIdx = bitIdx + 1'b1;

	//////////////////////////////////////////////////////////////////////
	// word latch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (link.start)
			wordQ <= link.word;
	end

	//////////////////////////////////////////////////////////////////////
	// sclk divider and bit counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy   <= 1'b0;
			divCnt <= '0;
			bitIdx <= '0;
		end else if (link.start) begin
			busy   <= 1'b1;                // bit 0 period starts next cycle
			divCnt <= '0;
			bitIdx <= '0;
		end else if (divWrap) begin
			divCnt <= '0;
			if (lastBit) begin
				busy   <= 1'b0;            // park divider at 0, sclk stays low
				bitIdx <= '0;
			end else begin
				bitIdx <= nextIdx;
			end
		end else if (busy) begin
			divCnt <= divCnt + 1'b1;
		end
	end

	// msb of divider: low for the first half of a bit period, high for the second
	assign sclk = divCnt[$bits(divCnt_t)-1];

	//////////////////////////////////////////////////////////////////////
	// data pin, chip select, word done
	//////////////////////////////////////////////////////////////////////

	// sdata only moves on a divider wrap, i.e. as sclk drops
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			sdata <= 1'b0;
		else if (link.start)
			sdata <= link.word[0];
		else if (divWrap)
			sdata <= lastBit ? 1'b0 : wordQ[nextIdx];   // idle low after the word
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			selectN <= 1'b1;
		else
			selectN <= ~link.frame;    // one cycle behind frame
	end

	// raised in the final clock of bit 31 so the next start costs only one gap cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			link.wordDone <= 1'b0;
		else
			link.wordDone <= busy && lastBit && (divCnt == DIV_DONE);
	end

endmodule

/* source/adcCmdSequencer.sv */
`timescale 1ns/1ps
`include "adcCtrl_cfg.svh"

// command decode and table walk, one start per register word
module adcCmdSequencer (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 init,
	input  logic                 desEnable,
	input  logic                 desDisable,
	output adcCtrlPkg::regAddr_t romAddr,
	input  adcCtrlPkg::regWord_t romWord,
	adcSerialIf.seq              link,
	output logic                 done
);
	import adcCtrlPkg::*;

	seqState_t state;
	seqState_t stateNext;
	regAddr_t  addrCnt;      // table address of current word
	regAddr_t  wordsLeft;    // words still to send after the current one
	logic      frameQ;

	logic      cmdValid;     // some command pulse present
	regAddr_t  cmdAddr;      // first table entry of that command
	regAddr_t  cmdLast;      // its word count minus one
	logic      accept;       // command taken this cycle
	logic      wordEnd;      // serializer finishing a word
	logic      lastWord;

	//////////////////////////////////////////////////////////////////////
	// command decode, init > desEnable > desDisable
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		cmdValid = init | desEnable | desDisable;
		cmdAddr  = regAddr_t'(`ADC_DESDIS_ADDR);
		cmdLast  = regAddr_t'(`ADC_DESDIS_WORDS - 1);
		if (init) begin
			cmdAddr = regAddr_t'(`ADC_INIT_ADDR);
			cmdLast = regAddr_t'(`ADC_INIT_WORDS - 1);
		end else if (desEnable) begin
			cmdAddr = regAddr_t'(`ADC_DESEN_ADDR);
			cmdLast = regAddr_t'(`ADC_DESEN_WORDS - 1);
		end
	end

	assign accept   = (state == seqIdle) && cmdValid;     // pulses elsewhere are dropped
	assign wordEnd  = (state == seqShift) && link.wordDone;
	assign lastWord = (wordsLeft == '0);

	//////////////////////////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		stateNext = state;
		case (state)
			seqIdle:   if (cmdValid) stateNext = seqLoad;
			seqLoad:   stateNext = seqShift;           // start goes out here
			seqShift: begin
				if (link.wordDone)
					stateNext = lastWord ? seqFinish : seqLoad;
			end
			seqFinish: stateNext = seqIdle;
			default:   stateNext = seqIdle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= seqIdle;
		else
			state <= stateNext;
	end

	//////////////////////////////////////////////////////////////////////
	// address and word counters, frame
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			addrCnt   <= '0;
			wordsLeft <= '0;
		end else if (accept) begin
			addrCnt   <= cmdAddr;
			wordsLeft <= cmdLast;
		end else if (wordEnd && !lastWord) begin
			addrCnt   <= addrCnt + 1'b1;      // step to next table entry
			wordsLeft <= wordsLeft - 1'b1;
		end
	end

	// high from the first load until the last word has gone out
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			frameQ <= 1'b0;
		else if (accept)
			frameQ <= 1'b1;
		else if (wordEnd && lastWord)
			frameQ <= 1'b0;
	end

	assign romAddr    = addrCnt;
	assign link.frame = frameQ;
	assign link.start = (state == seqLoad);
	assign link.word  = romWord;               // rom answers in the same cycle
	assign done       = (state == seqFinish);  // single-cycle strobe

endmodule

/* source/adcSerialCtrl.sv */
`timescale 1ns/1ps

// adc serial configuration controller, top level
module adcSerialCtrl (
	input  logic clk,
	input  logic rstN,
	input  logic init,          // write all eight config registers
	input  logic desEnable,     // turn dual-edge sampling on
	input  logic desDisable,    // turn dual-edge sampling off
	output logic sclk,
	output logic sdata,
	output logic selectN,
	output logic done           // one-cycle strobe at end of a sequence
);
	import adcCtrlPkg::*;

	regAddr_t romAddr;
	regWord_t romWord;

	//////////////////////////////////////////////////////////////////////
	// sequencer to serializer link
	//////////////////////////////////////////////////////////////////////

	adcSerialIf link ();

	//////////////////////////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////////////////////////

	adcCmdSequencer u_adcCmdSequencer (
		.clk        (clk),
		.rstN       (rstN),
		.init       (init),
		.desEnable  (desEnable),
		.desDisable (desDisable),
		.romAddr    (romAddr),
		.romWord    (romWord),
		.link       (link.seq),
		.done       (done)
	);

	// table lookup
	adcRegRom u_adcRegRom (
		.addr (romAddr),
		.data (romWord)
	);

	adcSerializer u_adcSerializer (
		.clk     (clk),
		.rstN    (rstN),
		.link    (link.ser),
		.sclk    (sclk),
		.sdata   (sdata),
		.selectN (selectN)
	);

endmodule

/* tb/adcSerialCtrl_assert.sv */
`timescale 1ns/1ps

// properties of the serial pins, bound into the controller top level
module adcSerialCtrl_assert (
	input logic clk,
	input logic rstN,
	input logic sclk,
	input logic sdata,
	input logic selectN,
	input logic done
);

	//////////////////////////////////////////////////////////////////////
	// strobe and chip select
	//////////////////////////////////////////////////////////////////////

	property donePulse;    // done is a single-cycle strobe
		@(posedge clk) disable iff (!rstN)
			done |=> !done;
	endproperty

	// done marks the last cycle of an open frame
	property doneInFrame;
		@(posedge clk) disable iff (!rstN)
			done |-> !selectN;
	endproperty

	//////////////////////////////////////////////////////////////////////
	// serial clock and data
	//////////////////////////////////////////////////////////////////////

	property sclkIdleLow;    // no clocking outside a frame
		@(posedge clk) disable iff (!rstN)
			selectN |-> !sclk;
	endproperty

	// data only moves while sclk is low
	property sdataHeld;
		@(posedge clk) disable iff (!rstN)
			(sclk && $past(sclk)) |-> $stable(sdata);
	endproperty

	doneOneCycle: assert property (donePulse)
		else $error("done stayed high for more than one cycle");
	doneInsideFrame: assert property (doneInFrame)
		else $error("done pulsed while selectN was high");
	sclkLowWhenIdle: assert property (sclkIdleLow)
		else $error("sclk high while selectN was high");
	sdataStableHigh: assert property (sdataHeld)
		else $error("sdata changed during an sclk high phase");

endmodule

bind adcSerialCtrl adcSerialCtrl_assert u_adcSerialCtrl_assert (.*);

/* tb/adcSerialCtrl_tb.sv */
`timescale 1ns/1ps
`include "adcCtrl_cfg.svh"

module adcSerialCtrl_tb;

	localparam int HALF_CLKS = `ADC_SCLK_DIV / 2;                // sclk half period
	localparam int WORD_CLKS = `ADC_SCLK_DIV * `ADC_WORD_BITS;   // clocks per word
	localparam int MARGIN    = 400;                              // watchdog slack

	logic clk = 1'b0;
	logic rstN, init, desEnable, desDisable;
	logic sclk, sdata, selectN, done;

	integer seed;
	int budget;                      // watchdog limit in clocks that grows per command
	int valErrs, otherErrs, issued;

	logic [2:0]  expCmds[$];         // accepted commands in issue order
	string       expNames[$];
	logic [31:0] rxWords[$];         // words seen on the wire
	int          frameSizes[$];      // words per finished frame
	int          frameLens[$];       // selectN low time per frame

	always #2 clk = ~clk;            // 4 ns period

	adcSerialCtrl u_adcSerialCtrl (
		.clk        (clk),
		.rstN       (rstN),
		.init       (init),
		.desEnable  (desEnable),
		.desDisable (desDisable),
		.sclk       (sclk),
		.sdata      (sdata),
		.selectN    (selectN),
		.done       (done)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] tableWord(input int addr);
		case (addr)
			0:       return `ADC_REG0;
			1:       return `ADC_REG1;
			2:       return `ADC_REG2;
			3:       return `ADC_REG3;
			4:       return `ADC_REG4;
			5:       return `ADC_REG5;
			6:       return `ADC_REG6;
			7:       return `ADC_REG7;
			8:       return `ADC_REG8;
			default: return 32'h0;
		endcase
	endfunction

	// cmd is {init, desEnable, desDisable}; returns the word count
	function automatic int expectedWords(input logic [2:0] cmd,
		output logic [31:0] words [0:`ADC_ROM_DEPTH-1]);
		int first;
		int count;
		int i;
		first = `ADC_DESDIS_ADDR;
		count = `ADC_DESDIS_WORDS;
		if (cmd[2]) begin            // init beats everything
			first = `ADC_INIT_ADDR;
			count = `ADC_INIT_WORDS;
		end else if (cmd[1]) begin
			first = `ADC_DESEN_ADDR;
			count = `ADC_DESEN_WORDS;
		end
		for (i = 0; i < `ADC_ROM_DEPTH; i++)
			words[i] = (i < count) ? tableWord(first + i) : 32'h0;
		return count;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// serial receiver and pin timing sampled mid-cycle
	//////////////////////////////////////////////////////////////////////

	logic        prevSclk, prevSelectN, prevDone;
	logic [31:0] shiftReg;
	int          highRun, lowRun, bitCnt, frameWords, lowCycles;
	int          doneCnt;

	always @(negedge clk) begin
		if (!rstN) begin
			prevSclk = 1'b0;
			prevSelectN = 1'b1;
			prevDone = 1'b0;
			highRun = 0;
			lowRun = 0;
			bitCnt = 0;
			frameWords = 0;
			lowCycles = 0;
			doneCnt = 0;
		end else begin
			if (done && !prevDone)
				doneCnt++;
			if (!selectN) begin
				lowCycles++;
				if (sclk && !prevSclk) begin             // sclk rising edge
					// first bit of a later word also carries the one gap cycle
					assert (lowRun == HALF_CLKS + ((bitCnt == 0 && frameWords > 0) ? 1 : 0))
					else begin
						otherErrs++;
						$display("sclk low phase lasted %0d clocks before bit %0d",
							lowRun, bitCnt);
					end
					shiftReg[bitCnt] = sdata;              // lsb arrives first
					bitCnt++;
					highRun = 1;
					if (bitCnt == `ADC_WORD_BITS) begin
						rxWords.push_back(shiftReg);
						frameWords++;
						bitCnt = 0;
					end
				end else if (sclk) begin
					highRun++;
				end else if (prevSclk) begin             // sclk falling edge
					assert (highRun == HALF_CLKS) else begin
						otherErrs++;
						$display("sclk high phase lasted %0d clocks", highRun);
					end
					lowRun = 1;
				end else begin
					lowRun++;
				end
			end else if (!prevSelectN) begin            // frame just closed
				assert (bitCnt == 0) else begin
					otherErrs++;
					$display("frame closed after only %0d sclk edges of a word", bitCnt);
				end
				assert (prevDone && !done) else begin
					otherErrs++;
					$display("done was not high in the cycle before selectN rose");
				end
				frameSizes.push_back(frameWords);
				frameLens.push_back(lowCycles);
				bitCnt = 0;
				frameWords = 0;
				lowCycles = 0;
				lowRun = 0;
			end else begin
				lowRun = 0;
			end
			prevSclk = sclk;
			prevSelectN = selectN;
			prevDone = done;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compare received frames with the reference
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] expWords [0:`ADC_ROM_DEPTH-1];
		logic [31:0] got;
		logic [2:0]  cmd;
		string       name;
		int          gotCount, gotLen, expCount, i;
		forever begin
			@(posedge clk);
			while (frameSizes.size() > 0) begin
				gotCount = frameSizes.pop_front();
				gotLen = frameLens.pop_front();
				assert (expCmds.size() != 0) else begin
					otherErrs++;
					$display("a frame of %0d words appeared with no command pending", gotCount);
				end
				if (expCmds.size() == 0) begin
					for (i = 0; i < gotCount; i++)
						void'(rxWords.pop_front());
				end else begin
					cmd = expCmds.pop_front();
					name = expNames.pop_front();
					expCount = expectedWords(cmd, expWords);
					assert (gotCount == expCount) else begin
						otherErrs++;
						$display("%s: received %0d words but %0d were due",
							name, gotCount, expCount);
					end
					for (i = 0; i < gotCount; i++) begin
						got = rxWords.pop_front();
						if (i < expCount) begin
							assert (got == expWords[i]) else begin
								valErrs++;
								$display("** Error %s word %0d: expected %08h, actual %08h",
									name, i, expWords[i], got);
							end
						end
					end
					// one bit time per bit, one gap per word boundary, one done cycle
					assert (gotLen == WORD_CLKS * expCount + (expCount - 1) + 1) else begin
						otherErrs++;
						$display("%s: selectN was low for %0d clocks", name, gotLen);
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= budget + MARGIN) begin
			@(posedge clk);
			cycles++;
		end
		$display("watchdog: run did not finish within %0d clocks", budget + MARGIN);
		$display("Result: FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// pulse a command while idle, then wait for done; noise adds stray pulses mid-frame
	task automatic issueCommand(input logic [2:0] cmd, input string name, input bit noise);
		logic [31:0] words [0:`ADC_ROM_DEPTH-1];
		int     n;
		int     gap;
		integer r;
		logic   quiet;
		logic   finished;
		n = expectedWords(cmd, words);
		gap = 2 + ($random(seed) & 7);
		budget += 530 * n + gap + 4;
		expCmds.push_back(cmd);
		expNames.push_back(name);
		issued++;
		@(posedge clk);
		{init, desEnable, desDisable} <= cmd;
		@(posedge clk);
		{init, desEnable, desDisable} <= 3'b000;
		do begin
			@(negedge clk);
			quiet = !selectN && !done;      // frame open and not in its last cycle
			finished = done;
			r = $random(seed);
			@(posedge clk);
			if (noise && quiet && r[2:0] == 3'd0)
				{init, desEnable, desDisable} <= r[6:4];
			else
				{init, desEnable, desDisable} <= 3'b000;
		end while (!finished);
		repeat (gap) @(posedge clk);
	endtask

	initial begin
		logic [2:0] cmd;
		integer     r;
		int         k;
		seed = 32'h6247;
		budget = 8;
		valErrs = 0;
		otherErrs = 0;
		issued = 0;
		rstN = 1'b0;
		init = 1'b0;
		desEnable = 1'b0;
		desDisable = 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		assert (selectN && !sclk && !done && !sdata) else begin
			otherErrs++;
			$display("pins not idle after reset");
		end

		// single commands
		issueCommand(3'b100, "init", 1'b0);
		issueCommand(3'b010, "desEnable", 1'b0);
		issueCommand(3'b001, "desDisable", 1'b0);

		// coinciding pulses
		issueCommand(3'b110, "init + desEnable", 1'b0);
		issueCommand(3'b011, "desEnable + desDisable", 1'b0);
		issueCommand(3'b101, "init + desDisable", 1'b0);
		issueCommand(3'b111, "all three", 1'b0);

		// random commands with stray pulses inside the frame
		for (k = 0; k < 3; k++) begin
			r = $random(seed);
			cmd = r[2:0];
			if (cmd == 3'b000)
				cmd = 3'b010;
			issueCommand(cmd, "random command", 1'b1);
		end
		issueCommand(3'b100, "init with noise", 1'b1);
		issueCommand(3'b001, "desDisable with noise", 1'b1);

		repeat (10) @(posedge clk);      // let the compare process drain
		assert (expCmds.size() == 0 && frameSizes.size() == 0) else begin
			otherErrs++;
			$display("%0d commands never produced a frame", expCmds.size());
		end
		assert (doneCnt == issued) else begin
			otherErrs++;
			$display("saw %0d done pulses for %0d commands", doneCnt, issued);
		end

		$display("checks finished: %0d value errors, %0d count or timing errors",
			valErrs, otherErrs);
		if (valErrs == 0 && otherErrs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
source/adcCtrlPkg.sv
source/adcSerialIf.sv
source/adcRegRom.sv
source/adcSerializer.sv
source/adcCmdSequencer.sv
source/adcSerialCtrl.sv
tb/adcSerialCtrl_assert.sv
tb/adcSerialCtrl_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := adcSerialCtrl_tb
FILELIST  := project.f
OBJDIR    := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJDIR)
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
